// File: Makefile
TOP := tb_banked_mem
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): tb.f $(shell grep -v '^+' tb.f)
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module $(TOP) -f tb.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
	  --top-module $(TOP) -f tb.f
	verilator --lint-only --assert --timescale 1ns/1ps --top-module banked_mem \
	  common/bank_pkg.sv src/req_fifo.sv mem_split/mem_split.sv \
	  src/bank_sram.sv src/banked_mem.sv

clean:
	rm -rf obj_dir $(LOG)

// File: common/bank_pkg.sv
package bank_pkg;

  // Byte address width of the wide port.
  // Each bank sees an address of the same width.
  localparam int unsigned ADDR_W = 16;

  // Width of the wide data word.
  localparam int unsigned DATA_W = 64;

  // Number of parallel banks behind the splitter.
  localparam int unsigned NUM_BANKS = 4;

  // Data width of one bank.
  localparam int unsigned BANK_W = DATA_W / NUM_BANKS;

  // Byte strobes per bank and on the wide port.
  localparam int unsigned BANK_BYTES = BANK_W / 8;
  localparam int unsigned DATA_BYTES = DATA_W / 8;

  // Byte offset bits inside one wide word.
  // Banks ignore these when picking a row.
  localparam int unsigned OFFSET_W = $clog2(DATA_BYTES);

  // Row index width inside a bank.
  localparam int unsigned ROW_W = 8;
  localparam int unsigned ROWS  = 2 ** ROW_W;

  // Depth of each per-bank request FIFO and response FIFO.
  localparam int unsigned FIFO_DEPTH = 2;

  // Outstanding skipped-write records.
  // The record FIFO holds one more entry than this.
  localparam int unsigned MAX_TRANS = 2;
  localparam int unsigned REC_DEPTH = MAX_TRANS + 1;

  // Bank writes with an all-zero strobe are not issued when set.
  localparam bit HIDE_STRB = 1'b1;

  // Width of one packed bank request.
  // Layout is address, write data, strobe, write enable.
  localparam int unsigned BANK_REQ_W = ADDR_W + BANK_W + BANK_BYTES + 1;

endpackage

// File: mem_split/mem_split.sv
module mem_split (
  input  logic                                                  clk_i,
  input  logic                                                  reset_i,
  // Wide request side.
  input  logic                                                  req_i,
  output logic                                                  gnt_o,
  input  logic [bank_pkg::ADDR_W-1:0]                           addr_i,
  input  logic                                                  we_i,
  input  logic [bank_pkg::DATA_W-1:0]                           wdata_i,
  input  logic [bank_pkg::DATA_BYTES-1:0]                       strb_i,
  // Wide response side.
  output logic                                                  rvalid_o,
  output logic [bank_pkg::DATA_W-1:0]                           rdata_o,
  // Bank request side.
  output logic [bank_pkg::NUM_BANKS-1:0]                        bank_req_o,
  input  logic [bank_pkg::NUM_BANKS-1:0]                        bank_gnt_i,
  output logic [bank_pkg::NUM_BANKS-1:0][bank_pkg::ADDR_W-1:0]     bank_addr_o,
  output logic [bank_pkg::NUM_BANKS-1:0]                        bank_we_o,
  output logic [bank_pkg::NUM_BANKS-1:0][bank_pkg::BANK_W-1:0]     bank_wdata_o,
  output logic [bank_pkg::NUM_BANKS-1:0][bank_pkg::BANK_BYTES-1:0] bank_strb_o,
  // Bank response side.
  input  logic [bank_pkg::NUM_BANKS-1:0]                        bank_rvalid_i,
  input  logic [bank_pkg::NUM_BANKS-1:0][bank_pkg::BANK_W-1:0]     bank_rdata_i
);

  logic req_xfer;
  logic [bank_pkg::ADDR_W-1:0] addr_aligned;

  // Per-bank request FIFO signals.
  logic [bank_pkg::NUM_BANKS-1:0][bank_pkg::BANK_REQ_W-1:0] req_in;
  logic [bank_pkg::NUM_BANKS-1:0][bank_pkg::BANK_REQ_W-1:0] req_head;
  logic [bank_pkg::NUM_BANKS-1:0] req_full;
  logic [bank_pkg::NUM_BANKS-1:0] req_empty;
  logic [bank_pkg::NUM_BANKS-1:0] req_pop;
  logic [bank_pkg::NUM_BANKS-1:0] head_skip;

  // Per-bank response FIFO signals.
  logic [bank_pkg::NUM_BANKS-1:0][bank_pkg::BANK_W-1:0] resp_data;
  logic [bank_pkg::NUM_BANKS-1:0] resp_full;
  logic [bank_pkg::NUM_BANKS-1:0] resp_empty;
  logic [bank_pkg::NUM_BANKS-1:0] resp_pop;

  // Skipped-write record signals.
  logic [bank_pkg::NUM_BANKS-1:0] in_skip;
  logic [bank_pkg::NUM_BANKS-1:0] rec_skip;
  logic rec_full;
  logic rec_empty;

  assign req_xfer = req_i && gnt_o;

  // Drop the byte offset; each bank adds its own lane offset.
  assign addr_aligned = {addr_i[bank_pkg::ADDR_W-1:bank_pkg::OFFSET_W],
                         {bank_pkg::OFFSET_W{1'b0}}};

  for (genvar i = 0; i < bank_pkg::NUM_BANKS; i++) begin : gen_bank
    // Bank slice of the wide request.
    assign req_in[i] = {addr_aligned + bank_pkg::ADDR_W'(i * bank_pkg::BANK_BYTES),
                        wdata_i[i*bank_pkg::BANK_W +: bank_pkg::BANK_W],
                        strb_i[i*bank_pkg::BANK_BYTES +: bank_pkg::BANK_BYTES],
                        we_i};

    // A zero-strobe write on the way in is noted in the record.
    assign in_skip[i] = bank_pkg::HIDE_STRB && we_i &&
                        (strb_i[i*bank_pkg::BANK_BYTES +: bank_pkg::BANK_BYTES] == '0);

    req_fifo #(
      .DEPTH        (bank_pkg::FIFO_DEPTH),
      .WIDTH        (bank_pkg::BANK_REQ_W),
      .FALL_THROUGH (1'b1)
    ) u_req_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .push_i  (req_xfer),
      .data_i  (req_in[i]),
      .full_o  (req_full[i]),
      .pop_i   (req_pop[i]),
      .data_o  (req_head[i]),
      .empty_o (req_empty[i])
    );

    // Unpack the head entry onto the bank port.
    assign bank_addr_o[i]  = req_head[i][bank_pkg::BANK_W + bank_pkg::BANK_BYTES + 1
                                         +: bank_pkg::ADDR_W];
    assign bank_wdata_o[i] = req_head[i][bank_pkg::BANK_BYTES + 1 +: bank_pkg::BANK_W];
    assign bank_strb_o[i]  = req_head[i][1 +: bank_pkg::BANK_BYTES];
    assign bank_we_o[i]    = req_head[i][0];

    // Zero-strobe writes at the head are dropped without a bank access.
    assign head_skip[i]  = bank_pkg::HIDE_STRB && bank_we_o[i] && (bank_strb_o[i] == '0);
    assign bank_req_o[i] = !req_empty[i] && !head_skip[i];
    assign req_pop[i]    = !req_empty[i] && (head_skip[i] || bank_gnt_i[i]);

    req_fifo #(
      .DEPTH        (bank_pkg::FIFO_DEPTH),
      .WIDTH        (bank_pkg::BANK_W),
      .FALL_THROUGH (1'b1)
    ) u_resp_fifo (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .push_i  (bank_rvalid_i[i]),
      .data_i  (bank_rdata_i[i]),
      .full_o  (resp_full[i]),
      .pop_i   (resp_pop[i]),
      .data_o  (resp_data[i]),
      .empty_o (resp_empty[i])
    );

    // Skipped banks have no reply to consume.
    assign resp_pop[i] = rvalid_o && !rec_skip[i];

    // A bank reply must never be dropped by its response FIFO.
    a_resp_room : assert property (@(posedge clk_i) disable iff (reset_i)
      bank_rvalid_i[i] |-> (!resp_full[i] || resp_pop[i]))
      else $error("bank %0d reply with response FIFO full", i);
  end

  // One record per accepted request, in request order.
  req_fifo #(
    .DEPTH        (bank_pkg::REC_DEPTH),
    .WIDTH        (bank_pkg::NUM_BANKS),
    .FALL_THROUGH (1'b0)
  ) u_rec_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (req_xfer),
    .data_i  (in_skip),
    .full_o  (rec_full),
    .pop_i   (rvalid_o),
    .data_o  (rec_skip),
    .empty_o (rec_empty)
  );

  // Accept only when every buffer has room.
  assign gnt_o = !(|req_full) && !(|resp_full) && !rec_full;

  // Join once every bank has replied or was skipped.
  assign rvalid_o = !rec_empty && (&(~resp_empty | rec_skip));
  assign rdata_o  = resp_data;

  // Bank replies are only held while a request is outstanding.
  a_resp_has_rec : assert property (@(posedge clk_i) disable iff (reset_i)
    rec_empty |-> (&resp_empty))
    else $error("bank reply without outstanding request");

endmodule

// File: src/bank_sram.sv
module bank_sram (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            stall_i,
  input  logic                            req_i,
  output logic                            gnt_o,
  input  logic [bank_pkg::ADDR_W-1:0]     addr_i,
  input  logic                            we_i,
  input  logic [bank_pkg::BANK_W-1:0]     wdata_i,
  input  logic [bank_pkg::BANK_BYTES-1:0] strb_i,
  output logic                            rvalid_o,
  output logic [bank_pkg::BANK_W-1:0]     rdata_o
);

  // Row storage.
  logic [bank_pkg::BANK_W-1:0] mem_q [bank_pkg::ROWS];

  logic [bank_pkg::ROW_W-1:0] row;
  logic                       xfer;

  // Another port holds the bank while stall is high.
  assign gnt_o = !stall_i;
  assign xfer  = req_i && gnt_o;

  // Row comes from the word address.
  // The byte offset in the wide word is ignored.
  assign row = addr_i[bank_pkg::ROW_W + bank_pkg::OFFSET_W - 1 : bank_pkg::OFFSET_W];

  // One response per transfer, reads and writes alike.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= xfer;
    end
  end

  // Read returns the row before this cycle's write.
  always_ff @(posedge clk_i) begin
    if (xfer) begin
      rdata_o <= mem_q[row];
      if (we_i) begin
        for (int b = 0; b < bank_pkg::BANK_BYTES; b++) begin
          if (strb_i[b]) begin
            mem_q[row][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end
    end
  end

  // A held-off request keeps its fields until the bank grants it.
  a_req_hold : assert property (@(posedge clk_i) disable iff (reset_i)
    (req_i && !gnt_o) |=> (req_i && $stable(addr_i) && $stable(we_i) &&
                           $stable(wdata_i) && $stable(strb_i)))
    else $error("bank request changed while stalled");

endmodule

// File: src/banked_mem.sv
module banked_mem (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           req_i,
  output logic                           gnt_o,
  input  logic [bank_pkg::ADDR_W-1:0]    addr_i,
  input  logic                           we_i,
  input  logic [bank_pkg::DATA_W-1:0]    wdata_i,
  input  logic [bank_pkg::DATA_BYTES-1:0] strb_i,
  output logic                           rvalid_o,
  output logic [bank_pkg::DATA_W-1:0]    rdata_o,
  input  logic [bank_pkg::NUM_BANKS-1:0] bank_stall_i
);

  // Splitter to bank wiring.
  logic [bank_pkg::NUM_BANKS-1:0]                           bank_req;
  logic [bank_pkg::NUM_BANKS-1:0]                           bank_gnt;
  logic [bank_pkg::NUM_BANKS-1:0][bank_pkg::ADDR_W-1:0]     bank_addr;
  logic [bank_pkg::NUM_BANKS-1:0]                           bank_we;
  logic [bank_pkg::NUM_BANKS-1:0][bank_pkg::BANK_W-1:0]     bank_wdata;
  logic [bank_pkg::NUM_BANKS-1:0][bank_pkg::BANK_BYTES-1:0] bank_strb;
  logic [bank_pkg::NUM_BANKS-1:0]                           bank_rvalid;
  logic [bank_pkg::NUM_BANKS-1:0][bank_pkg::BANK_W-1:0]     bank_rdata;

  // Wide port splitter and response join.
  mem_split u_mem_split (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_i         (req_i),
    .gnt_o         (gnt_o),
    .addr_i        (addr_i),
    .we_i          (we_i),
    .wdata_i       (wdata_i),
    .strb_i        (strb_i),
    .rvalid_o      (rvalid_o),
    .rdata_o       (rdata_o),
    .bank_req_o    (bank_req),
    .bank_gnt_i    (bank_gnt),
    .bank_addr_o   (bank_addr),
    .bank_we_o     (bank_we),
    .bank_wdata_o  (bank_wdata),
    .bank_strb_o   (bank_strb),
    .bank_rvalid_i (bank_rvalid),
    .bank_rdata_i  (bank_rdata)
  );

  // One memory per 16-bit lane.
  for (genvar i = 0; i < bank_pkg::NUM_BANKS; i++) begin : gen_bank
    bank_sram u_bank_sram (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .stall_i  (bank_stall_i[i]),
      .req_i    (bank_req[i]),
      .gnt_o    (bank_gnt[i]),
      .addr_i   (bank_addr[i]),
      .we_i     (bank_we[i]),
      .wdata_i  (bank_wdata[i]),
      .strb_i   (bank_strb[i]),
      .rvalid_o (bank_rvalid[i]),
      .rdata_o  (bank_rdata[i])
    );
  end

endmodule

// File: src/req_fifo.sv
module req_fifo #(
  parameter int unsigned DEPTH        = 2,
  parameter int unsigned WIDTH        = 8,
  parameter bit          FALL_THROUGH = 1'b0
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  output logic             full_o,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             empty_o
);

  // Pointer and counter widths.
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  // Storage array.
  logic [WIDTH-1:0] mem_q [DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;

  logic stored_empty;
  logic bypass;
  logic write_en;
  logic read_en;

  // Advance a pointer with wrap at DEPTH.
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    nxt = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  assign stored_empty = (count_q == '0);
  assign full_o       = (count_q == CNT_W'(DEPTH));

  // In fall-through mode a push into an empty FIFO that is popped
  // at once never touches the storage.
  assign bypass   = FALL_THROUGH && stored_empty && push_i && pop_i;
  assign write_en = push_i && !bypass;
  assign read_en  = pop_i && !stored_empty && !bypass;

  // Head of the FIFO.
  // Fall-through shows the incoming word while nothing is stored.
  always_comb begin
    empty_o = stored_empty;
    data_o  = mem_q[rd_ptr_q];
    if (FALL_THROUGH && stored_empty) begin
      empty_o = !push_i;
      data_o  = data_i;
    end
  end

  // Pointers and entry count.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (write_en) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (read_en) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q <= count_q + CNT_W'(write_en) - CNT_W'(read_en);
    end
  end

  // Payload storage.
  always_ff @(posedge clk_i) begin
    if (write_en) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // The producer must respect full unless it pops in the same cycle.
  a_no_overflow : assert property (@(posedge clk_i) disable iff (reset_i)
    (push_i && full_o) |-> pop_i)
    else $error("req_fifo push while full");

  // The consumer only pops a valid head.
  a_no_underflow : assert property (@(posedge clk_i) disable iff (reset_i)
    pop_i |-> !empty_o)
    else $error("req_fifo pop while empty");

endmodule

// File: tb.f
common/bank_pkg.sv
src/req_fifo.sv
mem_split/mem_split.sv
src/bank_sram.sv
src/banked_mem.sv
verification/tb_clock_gen.sv
verification/tb_checks.sv
verification/tb_banked_mem.sv

// File: verification/tb_banked_mem.sv
module tb_banked_mem;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned SEED       = 43607;
  localparam int unsigned FILL_REQS  = bank_pkg::ROWS;
  localparam int unsigned FULL_PAIRS = 40;
  localparam int unsigned PART_PAIRS = 40;
  localparam int unsigned SKIP_PAIRS = 20;
  localparam int unsigned STALL_REQS = 150;
  localparam int unsigned TOTAL_REQS = FILL_REQS + 2 * (FULL_PAIRS + PART_PAIRS + SKIP_PAIRS)
                                       + STALL_REQS;
  localparam int unsigned WATCHDOG_CYCLES = TOTAL_REQS * 40 + 200;

  logic                            clk;
  logic                            reset;
  logic                            req;
  logic                            gnt;
  logic [bank_pkg::ADDR_W-1:0]     addr;
  logic                            we;
  logic [bank_pkg::DATA_W-1:0]     wdata;
  logic [bank_pkg::DATA_BYTES-1:0] strb;
  logic                            rvalid;
  logic [bank_pkg::DATA_W-1:0]     rdata;
  logic [bank_pkg::NUM_BANKS-1:0]  bank_stall;

  int err_count;
  int accepted;
  int outstanding;
  int missing;
  bit stall_on;

  tb_clock_gen u_clock_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  banked_mem uut (
    .clk_i        (clk),
    .reset_i      (reset),
    .req_i        (req),
    .gnt_o        (gnt),
    .addr_i       (addr),
    .we_i         (we),
    .wdata_i      (wdata),
    .strb_i       (strb),
    .rvalid_o     (rvalid),
    .rdata_o      (rdata),
    .bank_stall_i (bank_stall)
  );

  tb_checks u_checks (
    .clk_i         (clk),
    .reset_i       (reset),
    .req_i         (req),
    .gnt_i         (gnt),
    .addr_i        (addr),
    .we_i          (we),
    .wdata_i       (wdata),
    .strb_i        (strb),
    .rvalid_i      (rvalid),
    .rdata_i       (rdata),
    .stall_i       (bank_stall),
    .err_count_o   (err_count),
    .accepted_o    (accepted),
    .outstanding_o (outstanding)
  );

  // Fill value per byte, mixing low and high address bits.
  function automatic logic [bank_pkg::DATA_W-1:0] fill_word(input int unsigned row);
    logic [bank_pkg::DATA_W-1:0] w;
    int unsigned a;
    for (int b = 0; b < bank_pkg::DATA_BYTES; b++) begin
      a = row * bank_pkg::DATA_BYTES + b;
      w[b*8 +: 8] = 8'((a * 13) ^ (a >> 5) ^ 32'h5a);
    end
    return w;
  endfunction

  // Row address with a random byte offset, which the DUT ignores.
  function automatic logic [bank_pkg::ADDR_W-1:0] row_addr(input int unsigned row);
    logic [bank_pkg::ADDR_W-1:0] a;
    a = '0;
    a[bank_pkg::ROW_W + bank_pkg::OFFSET_W - 1 : bank_pkg::OFFSET_W] = bank_pkg::ROW_W'(row);
    a[bank_pkg::OFFSET_W-1:0] = bank_pkg::OFFSET_W'($urandom_range(0, bank_pkg::DATA_BYTES - 1));
    return a;
  endfunction

  function automatic logic [bank_pkg::DATA_W-1:0] rand_word();
    return {$urandom, $urandom};
  endfunction

  // Each lane is either silent or gets a nonzero strobe.
  function automatic logic [bank_pkg::DATA_BYTES-1:0] lane_strobe();
    logic [bank_pkg::DATA_BYTES-1:0] s;
    for (int i = 0; i < bank_pkg::NUM_BANKS; i++) begin
      s[i*bank_pkg::BANK_BYTES +: bank_pkg::BANK_BYTES] = '0;
      if ($urandom_range(0, 1) == 1) begin
        s[i*bank_pkg::BANK_BYTES +: bank_pkg::BANK_BYTES] =
          bank_pkg::BANK_BYTES'($urandom_range(1, (1 << bank_pkg::BANK_BYTES) - 1));
      end
    end
    return s;
  endfunction

  // Step to the next falling edge, re-rolling bank contention.
  task automatic next_cycle();
    @(negedge clk);
    if (stall_on) begin
      for (int i = 0; i < bank_pkg::NUM_BANKS; i++) begin
        bank_stall[i] = ($urandom_range(0, 2) == 0);
      end
    end
  endtask

  task automatic idle_cycles(input int unsigned n);
    repeat (n) next_cycle();
  endtask

  // Hold the request until the checker has counted it as accepted.
  task automatic send_request(
    input logic                            wr,
    input logic [bank_pkg::ADDR_W-1:0]     a,
    input logic [bank_pkg::DATA_W-1:0]     d,
    input logic [bank_pkg::DATA_BYTES-1:0] s
  );
    int start;
    start = accepted;
    req   = 1'b1;
    we    = wr;
    addr  = a;
    wdata = d;
    strb  = s;
    do begin
      next_cycle();
    end while (accepted == start);
    req = 1'b0;
  endtask

  // Read-back uses a different byte offset on the same row.
  task automatic write_then_read(
    input int unsigned                     row,
    input logic [bank_pkg::DATA_W-1:0]     d,
    input logic [bank_pkg::DATA_BYTES-1:0] s
  );
    send_request(1'b1, row_addr(row), d, s);
    send_request(1'b0, row_addr(row), rand_word(), '0);
  endtask

  initial begin : stimulus
    int unsigned row;
    void'($urandom(SEED));
    req        = 1'b0;
    we         = 1'b0;
    addr       = '0;
    wdata      = '0;
    strb       = '0;
    bank_stall = '0;
    stall_on   = 1'b0;
    missing    = 0;
    @(negedge reset);
    idle_cycles(4);
    // Known contents in every row.
    for (int r = 0; r < FILL_REQS; r++) begin
      send_request(1'b1, row_addr(r), fill_word(r), '1);
    end
    for (int n = 0; n < FULL_PAIRS; n++) begin
      row = $urandom_range(0, bank_pkg::ROWS - 1);
      write_then_read(row, rand_word(), '1);
    end
    // Random byte strobes.
    for (int n = 0; n < PART_PAIRS; n++) begin
      row = $urandom_range(0, bank_pkg::ROWS - 1);
      write_then_read(row, rand_word(), bank_pkg::DATA_BYTES'($urandom));
    end
    // Whole lanes left out, first a write with no strobe at all.
    write_then_read(7, rand_word(), '0);
    for (int n = 1; n < SKIP_PAIRS; n++) begin
      row = $urandom_range(0, bank_pkg::ROWS - 1);
      write_then_read(row, rand_word(), lane_strobe());
    end
    // Mixed traffic on a few rows under random contention.
    stall_on = 1'b1;
    for (int n = 0; n < STALL_REQS; n++) begin
      row = $urandom_range(0, 15);
      send_request(1'($urandom_range(0, 1)), row_addr(row), rand_word(), lane_strobe());
      if ($urandom_range(0, 7) == 0) begin
        idle_cycles(1);
      end
    end
    stall_on   = 1'b0;
    bank_stall = '0;
    for (int n = 0; n < 100 && outstanding != 0; n++) begin
      @(negedge clk);
    end
    missing = outstanding;
    $display("Checks failed: %0d, missing responses: %0d, accepted requests: %0d",
             err_count, missing, accepted);
    if (err_count == 0 && missing == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles.", WATCHDOG_CYCLES);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: verification/tb_checks.sv
module tb_checks (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic                            req_i,
  input  logic                            gnt_i,
  input  logic [bank_pkg::ADDR_W-1:0]     addr_i,
  input  logic                            we_i,
  input  logic [bank_pkg::DATA_W-1:0]     wdata_i,
  input  logic [bank_pkg::DATA_BYTES-1:0] strb_i,
  input  logic                            rvalid_i,
  input  logic [bank_pkg::DATA_W-1:0]     rdata_i,
  input  logic [bank_pkg::NUM_BANKS-1:0]  stall_i,
  output int                              err_count_o,
  output int                              accepted_o,
  output int                              outstanding_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Byte image of the 2 KB memory, plus a flag once a byte is written.
  logic [7:0] mem_model [bank_pkg::ROWS * bank_pkg::DATA_BYTES];
  bit         known     [bank_pkg::ROWS * bank_pkg::DATA_BYTES];

  // Expected response per accepted request, in request order.
  // The mask marks the bytes whose value is defined.
  logic [bank_pkg::DATA_W-1:0] exp_data_q [$];
  logic [bank_pkg::DATA_W-1:0] exp_mask_q [$];
  logic [bank_pkg::DATA_W-1:0] head_data = '0;
  logic [bank_pkg::DATA_W-1:0] head_mask = '0;

  int err_count   = 0;
  int accepted    = 0;
  int outstanding = 0;

  assign err_count_o   = err_count;
  assign accepted_o    = accepted;
  assign outstanding_o = outstanding;

  task automatic report_error(input string msg);
    err_count++;
    $display("FAIL %0t ns: %s", $time, msg);
  endtask

  always @(posedge clk_i) begin : model_update
    logic [bank_pkg::DATA_W-1:0] exp_data;
    logic [bank_pkg::DATA_W-1:0] exp_mask;
    int base;
    int lane;
    bit lane_on;
    if (reset_i) begin
      exp_data_q.delete();
      exp_mask_q.delete();
    end else begin
      // Retire the head first, a new request lands behind it.
      if (rvalid_i && exp_data_q.size() > 0) begin
        void'(exp_data_q.pop_front());
        void'(exp_mask_q.pop_front());
      end
      if (req_i && gnt_i) begin
        // Row is taken from address bits 10 down to 3.
        base = int'(addr_i[bank_pkg::ROW_W + bank_pkg::OFFSET_W - 1 : bank_pkg::OFFSET_W]);
        base = base * bank_pkg::DATA_BYTES;
        for (int b = 0; b < bank_pkg::DATA_BYTES; b++) begin
          lane    = b / bank_pkg::BANK_BYTES;
          // A zero-strobe write lane never reaches its bank.
          lane_on = !(bank_pkg::HIDE_STRB && we_i &&
                      strb_i[lane*bank_pkg::BANK_BYTES +: bank_pkg::BANK_BYTES] == '0);
          // Banks reply with the contents before the write.
          exp_data[b*8 +: 8] = mem_model[base + b];
          exp_mask[b*8 +: 8] = (lane_on && known[base + b]) ? 8'hff : 8'h00;
          if (we_i && strb_i[b]) begin
            mem_model[base + b] = wdata_i[b*8 +: 8];
            known[base + b]     = 1'b1;
          end
        end
        exp_data_q.push_back(exp_data);
        exp_mask_q.push_back(exp_mask);
        accepted++;
      end
    end
    outstanding = exp_data_q.size();
    head_data   = '0;
    head_mask   = '0;
    if (outstanding > 0) begin
      head_data = exp_data_q[0];
      head_mask = exp_mask_q[0];
    end
  end

  // Every response is owed to an accepted request.
  a_rvalid_owed : assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_i |-> (outstanding > 0))
    else report_error("rvalid_o with no outstanding request");

  // Response data matches the oldest request, which also checks order.
  a_rdata_match : assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_i |-> ((rdata_i & head_mask) == (head_data & head_mask)))
    else report_error($sformatf("rdata_o %h, expected %h under mask %h",
                                $sampled(rdata_i), $sampled(head_data),
                                $sampled(head_mask)));

  // An idle port with no contention must accept.
  a_idle_grant : assert property (@(posedge clk_i) disable iff (reset_i)
    (stall_i == '0 && outstanding == 0) |-> gnt_i)
    else report_error("gnt_o low with no stall and nothing outstanding");

  // Buffering bounds the number of requests in flight.
  a_outstanding_max : assert property (@(posedge clk_i) disable iff (reset_i)
    outstanding <= bank_pkg::MAX_TRANS + bank_pkg::FIFO_DEPTH)
    else report_error($sformatf("%0d requests outstanding", $sampled(outstanding)));

endmodule

// File: verification/tb_clock_gen.sv
module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned HALF_PERIOD  = 50;
  localparam int unsigned RESET_CYCLES = 4;

  // Free-running 100 ns clock.
  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Reset covers the first rising edges and drops on a falling edge.
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule
